/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := ex_stage_tb
FILELIST := ex_stage.f
LOG      := sim.log

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bench/ex_stage_tb.sv */
// testbench with clock and reset, stimulus tasks, reference model, comparing process and watchdog
`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb import ex_pkg::*; ();

    localparam int RST_CYCLES = 10;
    localparam int N_LS       = 40;
    localparam int N_AR       = 10 * 16 + 40;
    localparam int N_MUL      = 8 * 7;
    localparam int N_MAC      = 8 * 16;
    localparam int WATCHDOG_CYCLES = RST_CYCLES + 3 * (N_LS + N_AR + N_MUL + N_MAC) + 200;

    localparam alu_op_e LS_OPS [7] = '{OP_AND, OP_OR, OP_NOR, OP_XOR, OP_SLL, OP_SRL, OP_SRA};
    localparam alu_op_e AR_OPS [10] = '{OP_ADD, OP_ADDU, OP_ADDI, OP_ADDIU, OP_SUB, OP_SUBU,
                                        OP_SLT, OP_SLTU, OP_CLZ, OP_CLO};
    localparam alu_op_e MAC_OPS [4] = '{OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
    localparam logic [31:0] CORNER [4] = '{32'h0, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
    localparam logic [31:0] MUL_A [4] = '{32'hffff_fffd, 32'h8000_0000,
                                          32'h7fff_ffff, 32'hffff_ffff};
    localparam logic [31:0] MUL_B [4] = '{32'h0000_0007, 32'hffff_ffff,
                                          32'h8000_0000, 32'hffff_ffff};

    logic       clk;
    logic       rst_n;
    ex_req_t    req;
    logic [4:0] waddr;
    ex_wb_t     o_wb;
    logic [4:0] o_waddr;
    logic       o_stall;
    hilo_t      o_hilo;

    integer seed = 32'headf_02e4;
    int     errors = 0;
    int     checks = 0;
    int     tests_run = 0;
    int     tests_failed = 0;

    ex_wb_t     exp_wb;
    logic [4:0] exp_waddr;
    logic       exp_pend = 1'b0;
    logic       hilo_pend = 1'b0;
    hilo_t      model_hilo = '0;   // model copy of hi/lo

    ex_stage_top #(.REG_ADDR_W(5)) dut (
        .i_clk   (clk),
        .i_rst_n (rst_n),
        .i_req   (req),
        .i_waddr (waddr),
        .o_wb    (o_wb),
        .o_waddr (o_waddr),
        .o_stall (o_stall),
        .o_hilo  (o_hilo)
    );

    always #2 clk = ~clk;

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] rnd32();
        return $random(seed);
    endfunction

    function automatic int pick_index(input int n);
        logic [31:0] v;
        v = $random(seed);
        return int'(v[30:0]) % n;
    endfunction

    function automatic alu_sel_e sel_of(input alu_op_e op);
        case (op)
        OP_AND, OP_OR, OP_NOR, OP_XOR:      return SEL_LOGIC;
        OP_SLL, OP_SRL, OP_SRA:             return SEL_SHIFT;
        OP_MFHI, OP_MFLO, OP_MOVZ, OP_MOVN: return SEL_MOVE;
        OP_MUL:                             return SEL_MUL;
        OP_NOP, OP_MULT, OP_MULTU, OP_MTHI, OP_MTLO,
        OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU: return SEL_NONE;
        default:                            return SEL_ARITH;
        endcase
    endfunction

    // ops that only touch hi/lo leave the register file alone
    function automatic logic wen_of(input alu_op_e op);
        return !(op inside {OP_NOP, OP_MULT, OP_MULTU, OP_MTHI, OP_MTLO,
                            OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU});
    endfunction

    // expected write-back for one accepted op, h is hi/lo before the op
    function automatic ex_wb_t ref_wb(input ex_req_t r, input hilo_t h);
        logic [31:0] a;
        logic [31:0] b;
        logic [32:0] s;
        logic        ovf;
        logic [31:0] d;
        int          n;
        a = r.op0;
        b = r.op1;
        ovf = 1'b0;
        d = '0;
        n = 0;
        case (r.alu_op)
        OP_AND:  d = a & b;
        OP_OR:   d = a | b;
        OP_NOR:  d = ~(a | b);
        OP_XOR:  d = a ^ b;
        OP_SLL:  d = b << a[4:0];
        OP_SRL:  d = b >> a[4:0];
        OP_SRA:  d = $signed(b) >>> a[4:0];
        OP_ADD, OP_ADDI, OP_SUB: begin
            s = (r.alu_op == OP_SUB) ? {a[31], a} - {b[31], b} : {a[31], a} + {b[31], b};
            ovf = s[32] ^ s[31];   // 33-bit signed result out of range
            d = s[31:0];
        end
        OP_ADDU, OP_ADDIU: d = a + b;
        OP_SUBU: d = a - b;
        OP_SLT:  d = {31'b0, $signed(a) < $signed(b)};
        OP_SLTU: d = {31'b0, a < b};
        OP_CLZ, OP_CLO: begin
            while (n < 32 && a[31-n] == (r.alu_op == OP_CLO)) n++;
            d = 32'(n);
        end
        OP_MUL:  d = a * b;
        OP_MFHI: d = h.hi;
        OP_MFLO: d = h.lo;
        OP_MOVZ, OP_MOVN: d = a;
        default: d = '0;
        endcase
        return '{vld: 1'b1, wen: r.wen && !ovf, wdata: d, ov: ovf};
    endfunction

    task automatic update_hilo(input ex_req_t r, inout hilo_t h, output logic wrote);
        logic [63:0] sp;
        logic [63:0] up;
        sp = {{32{r.op0[31]}}, r.op0} * {{32{r.op1[31]}}, r.op1};
        up = {32'b0, r.op0} * {32'b0, r.op1};
        wrote = 1'b1;
        case (r.alu_op)
        OP_MULT:  {h.hi, h.lo} = sp;
        OP_MULTU: {h.hi, h.lo} = up;
        OP_MADD:  {h.hi, h.lo} = {h.hi, h.lo} + sp;
        OP_MADDU: {h.hi, h.lo} = {h.hi, h.lo} + up;
        OP_MSUB:  {h.hi, h.lo} = {h.hi, h.lo} - sp;
        OP_MSUBU: {h.hi, h.lo} = {h.hi, h.lo} - up;
        OP_MTHI:  h.hi = r.op0;
        OP_MTLO:  h.lo = r.op0;
        default:  wrote = 1'b0;
        endcase
    endtask

    // compare at the falling edge, then note what the next edge accepts
    always @(negedge clk) begin
        if (!rst_n) begin
            exp_pend = 1'b0;
            hilo_pend = 1'b0;
        end else begin
            if (exp_pend) begin
                check_value(64'(o_wb.vld), 64'd1, "wb vld");
                check_value(64'(o_wb.wen), 64'(exp_wb.wen), "wb wen");
                check_value(64'(o_wb.ov), 64'(exp_wb.ov), "wb ov");
                check_value(64'(o_wb.wdata), 64'(exp_wb.wdata), "wb wdata");
                check_value(64'(o_waddr), 64'(exp_waddr), "wb waddr");
            end else begin
                check_value(64'(o_wb.vld), 64'd0, "wb vld while idle");
                check_value(64'(o_wb.wen), 64'd0, "wb wen while idle");
            end
            if (hilo_pend) check_value(64'(o_hilo), 64'(model_hilo), "hi/lo");
            exp_pend = req.vld && !o_stall;
            hilo_pend = 1'b0;
            if (exp_pend) begin
                exp_wb = ref_wb(req, model_hilo);
                exp_waddr = waddr;
                update_hilo(req, model_hilo, hilo_pend);
            end
        end
    end

    // drive one op at the current rising edge, hold it through any stall
    task automatic issue(input alu_op_e op, input logic [31:0] a, input logic [31:0] b);
        int stalls;
        stalls = 0;
        req <= '{vld: 1'b1, alu_op: op, alu_sel: sel_of(op), op0: a, op1: b, wen: wen_of(op)};
        waddr <= 5'($random(seed));
        @(negedge clk);
        while (o_stall) begin
            stalls++;
            @(negedge clk);
        end
        @(posedge clk);
        check_value(64'(stalls),
                    (op inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU}) ? 64'd1 : 64'd0,
                    "stall cycles");
    endtask

    task automatic finish_test(input string name, input int err_before);
        req <= '0;
        repeat (3) @(posedge clk);   // let the last result be compared
        tests_run++;
        if (errors != err_before) tests_failed++;
        $display("test %s %s, %0d errors", name, (errors == err_before) ? "ok" : "FAILED",
                 errors - err_before);
    endtask

    task automatic expect_idle(input string when);
        check_value(64'(o_wb.vld), 64'd0, {"wb vld ", when});
        check_value(64'(o_wb.wen), 64'd0, {"wb wen ", when});
        check_value(64'(o_stall), 64'd0, {"stall ", when});
        check_value(64'(o_hilo), 64'd0, {"hi/lo ", when});
    endtask

    task automatic logic_shift_ops();
        logic [31:0] a;
        for (int i = 0; i < N_LS; i++) begin
            a = rnd32();
            if (i % 3 == 0) a[4:0] = 5'd0;
            else if (i % 3 == 1) a[4:0] = 5'd31;
            issue(LS_OPS[pick_index(7)], a, rnd32());
        end
    endtask

    task automatic arith_ops();
        foreach (AR_OPS[k]) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) issue(AR_OPS[k], CORNER[i], CORNER[j]);
            end
        end
        for (int i = 0; i < N_AR - 160; i++) begin
            issue(AR_OPS[pick_index(10)], rnd32() >> (i % 32), rnd32());  // varied leading zeros
        end
    endtask

    task automatic multiply_ops();
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < 8; i++) begin
            a = (i < 4) ? MUL_A[i % 4] : rnd32();
            b = (i < 4) ? MUL_B[i % 4] : rnd32();
            issue(OP_MULT, a, b);
            issue(OP_MFHI, '0, '0);
            issue(OP_MFLO, '0, '0);
            issue(OP_MULTU, a, b);
            issue(OP_MFHI, '0, '0);
            issue(OP_MFLO, '0, '0);
            issue(OP_MUL, a, b);
        end
    endtask

    task automatic mac_and_moves();
        for (int i = 0; i < 8; i++) begin
            issue(OP_MTHI, rnd32(), '0);
            issue(OP_MTLO, rnd32(), '0);
            foreach (MAC_OPS[k]) begin
                issue(MAC_OPS[k], rnd32(), rnd32());
                issue(OP_MFHI, '0, '0);
                issue(OP_MFLO, '0, '0);
            end
            issue(OP_MOVZ, rnd32(), '0);
            issue(OP_MOVN, rnd32(), rnd32());
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        req = '0;
        waddr = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        expect_idle("in reset");
        repeat (RST_CYCLES - 5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        expect_idle("after reset");
        finish_test("reset", 0);
        begin
            int e;
            e = errors;
            logic_shift_ops();
            finish_test("logic_shift", e);
            e = errors;
            arith_ops();
            finish_test("arith", e);
            e = errors;
            multiply_ops();
            finish_test("multiply", e);
            e = errors;
            mac_and_moves();
            finish_test("mac_moves", e);
        end
        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* ex_stage.f */
verilog/ex_pkg.sv
verilog/alu_logic_shift.sv
verilog/alu_arith.sv
verilog/alu_mul.sv
verilog/hilo_unit.sv
verilog/ex_result_reg.sv
verilog/ex_stage_top.sv
bench/ex_stage_tb.sv

/* verilog/alu_arith.sv */
// alu_arith: add/sub adder, set-less-than, clz/clo and signed overflow
`timescale 1ns/1ps
`default_nettype none

module alu_arith import ex_pkg::*; (
    input  ex_req_t         i_req,
    output logic [XLEN-1:0] o_arith_out,
    output logic            o_ov
);

    logic            is_sub;
    logic [XLEN-1:0] add_b;     // second adder input
    logic [XLEN-1:0] sum;
    logic            lt_signed;
    logic            lt;
    logic [XLEN-1:0] cnt_src;
    logic [5:0]      lead_cnt;  // 0..32

    assign is_sub = i_req.alu_op inside {OP_SUB, OP_SUBU, OP_SLT};

    // two's complement as inverted op1 plus carry in
    assign add_b = is_sub ? ~i_req.op1 : i_req.op1;
    assign sum   = i_req.op0 + add_b + {{(XLEN-1){1'b0}}, is_sub};

    // signs differ, or same sign and the difference is negative
    assign lt_signed = (i_req.op0[XLEN-1] & ~i_req.op1[XLEN-1])
                     | (~(i_req.op0[XLEN-1] ^ i_req.op1[XLEN-1]) & sum[XLEN-1]);
    assign lt = (i_req.alu_op == OP_SLT) ? lt_signed : (i_req.op0 < i_req.op1);

    assign o_ov = (i_req.alu_op inside {OP_ADD, OP_ADDI, OP_SUB})
                && (i_req.op0[XLEN-1] == add_b[XLEN-1])
                && (sum[XLEN-1] != i_req.op0[XLEN-1]);

    assign cnt_src = (i_req.alu_op == OP_CLO) ? ~i_req.op0 : i_req.op0;

    // highest set bit wins
    always_comb begin
        lead_cnt = 6'd32;
        for (int i = 0; i < XLEN; i++) begin
            if (cnt_src[i]) begin
                lead_cnt = 6'(XLEN - 1 - i);
            end
        end
    end

    always_comb begin
        case (i_req.alu_op)
        OP_ADD, OP_ADDU, OP_ADDI, OP_ADDIU, OP_SUB, OP_SUBU: begin
            o_arith_out = sum;
        end
        OP_SLT, OP_SLTU: o_arith_out = {{(XLEN-1){1'b0}}, lt};
        OP_CLZ, OP_CLO:  o_arith_out = {{(XLEN-6){1'b0}}, lead_cnt};
        default:         o_arith_out = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/alu_logic_shift.sv */
// alu_logic_shift: and/or/nor/xor and sll/srl/sra results
`timescale 1ns/1ps
`default_nettype none

module alu_logic_shift import ex_pkg::*; (
    input  ex_req_t         i_req,
    output logic [XLEN-1:0] o_logic_out,
    output logic [XLEN-1:0] o_shift_out
);

    logic [4:0] shamt;

    assign shamt = i_req.op0[4:0];  // shift amount from rs

    always_comb begin
        case (i_req.alu_op)
        OP_AND:  o_logic_out = i_req.op0 & i_req.op1;
        OP_OR:   o_logic_out = i_req.op0 | i_req.op1;
        OP_NOR:  o_logic_out = ~(i_req.op0 | i_req.op1);
        OP_XOR:  o_logic_out = i_req.op0 ^ i_req.op1;
        default: o_logic_out = '0;
        endcase
    end

    // op1 is the value being shifted
    always_comb begin
        case (i_req.alu_op)
        OP_SLL: begin
            o_shift_out = i_req.op1 << shamt;
        end
        OP_SRL: begin
            o_shift_out = i_req.op1 >> shamt;
        end
        OP_SRA: begin
            o_shift_out = $signed(i_req.op1) >>> shamt;  // sign fill
        end
        default: begin
            o_shift_out = '0;
        end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/alu_mul.sv */
// alu_mul: 32x32 multiply, signed through magnitudes and sign correction
`timescale 1ns/1ps
`default_nettype none

module alu_mul import ex_pkg::*; (
    input  ex_req_t           i_req,
    output logic [2*XLEN-1:0] o_product
);

    logic              is_signed;
    logic              neg_res;   // operand signs differ
    logic [XLEN-1:0]   mag0;
    logic [XLEN-1:0]   mag1;
    logic [2*XLEN-1:0] mag_prod;

    assign is_signed = i_req.alu_op inside {OP_MULT, OP_MUL, OP_MADD, OP_MSUB};

    // magnitudes of negative operands for signed ops
    assign mag0 = (is_signed && i_req.op0[XLEN-1]) ? (~i_req.op0 + 1'b1) : i_req.op0;
    assign mag1 = (is_signed && i_req.op1[XLEN-1]) ? (~i_req.op1 + 1'b1) : i_req.op1;

    assign mag_prod = {{XLEN{1'b0}}, mag0} * {{XLEN{1'b0}}, mag1};

    assign neg_res = is_signed && (i_req.op0[XLEN-1] ^ i_req.op1[XLEN-1]);

    always_comb begin
        if (neg_res) begin
            o_product = ~mag_prod + 1'b1;
        end else begin
            o_product = mag_prod;  // unsigned or same sign
        end
    end

endmodule

`default_nettype wire

/* verilog/ex_pkg.sv */
// register width, opcode/selector/sequencer enums, request, write-back and hi/lo structs
`default_nettype none

package ex_pkg;

    localparam int XLEN = 32;  // one general register word

    // opcodes kept in this execute stage
    typedef enum logic [7:0] {
        OP_NOP = 8'h00,
        OP_AND, OP_OR, OP_NOR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA,
        OP_ADD, OP_ADDU, OP_ADDI, OP_ADDIU, OP_SUB, OP_SUBU,
        OP_SLT, OP_SLTU, OP_CLZ, OP_CLO,
        OP_MULT, OP_MULTU, OP_MUL,
        OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU,
        OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO, OP_MOVZ, OP_MOVN
    } alu_op_e;

    // which result feeds the write-back data
    typedef enum logic [2:0] {
        SEL_NONE, SEL_LOGIC, SEL_SHIFT, SEL_ARITH, SEL_MOVE, SEL_MUL
    } alu_sel_e;

    typedef enum logic {
        MAC_IDLE,
        MAC_ACC    // second cycle of madd/msub
    } mac_state_e;

    typedef struct packed {
        logic            vld;
        alu_op_e         alu_op;
        alu_sel_e        alu_sel;
        logic [XLEN-1:0] op0;
        logic [XLEN-1:0] op1;
        logic            wen;   // register write request
    } ex_req_t;

    typedef struct packed {
        logic            vld;
        logic            wen;
        logic [XLEN-1:0] wdata;
        logic            ov;    // signed overflow seen, write dropped
    } ex_wb_t;

    typedef struct packed {
        logic [XLEN-1:0] hi;
        logic [XLEN-1:0] lo;
    } hilo_t;

endpackage

`default_nettype wire

/* verilog/ex_result_reg.sv */
// ex_result_reg: result select, overflow write drop and write-back register
`timescale 1ns/1ps
`default_nettype none

module ex_result_reg import ex_pkg::*; #(
    parameter int REG_ADDR_W = 5
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  ex_req_t               i_req,
    input  logic [REG_ADDR_W-1:0] i_waddr,
    input  logic [XLEN-1:0]       i_logic_out,
    input  logic [XLEN-1:0]       i_shift_out,
    input  logic [XLEN-1:0]       i_arith_out,
    input  logic                  i_ov,
    input  logic [2*XLEN-1:0]     i_product,
    input  hilo_t                 i_hilo,
    input  logic                  i_stall,
    output ex_wb_t                o_wb,
    output logic [REG_ADDR_W-1:0] o_waddr
);

    logic            accept;
    logic [XLEN-1:0] wdata;
    logic            wb_vld;
    logic            wb_wen;
    logic            wb_ov;
    logic [XLEN-1:0] wb_wdata;

    assign accept = i_req.vld && !i_stall;

    always_comb begin
        case (i_req.alu_sel)
        SEL_LOGIC: wdata = i_logic_out;
        SEL_SHIFT: wdata = i_shift_out;
        SEL_ARITH: wdata = i_arith_out;
        SEL_MOVE: begin
            case (i_req.alu_op)
            OP_MFHI:          wdata = i_hilo.hi;
            OP_MFLO:          wdata = i_hilo.lo;
            OP_MOVZ, OP_MOVN: wdata = i_req.op0;  // condition checked upstream
            default:          wdata = '0;
            endcase
        end
        SEL_MUL:   wdata = i_product[XLEN-1:0];  // low word only
        default:   wdata = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            wb_vld <= 1'b0;
            wb_wen <= 1'b0;
            wb_ov  <= 1'b0;
        end else begin
            wb_vld <= accept;
            wb_wen <= i_req.vld && i_req.wen && !i_ov;
            wb_ov  <= accept && i_ov;
        end
    end

    always_ff @(posedge i_clk) begin
        wb_wdata <= wdata;
        o_waddr  <= i_waddr;
    end

    assign o_wb = '{vld: wb_vld, wen: wb_wen, wdata: wb_wdata, ov: wb_ov};

    // a madd/msub stall cycle must not carry a write request
    a_wen_vld: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb.wen |-> o_wb.vld);

endmodule

`default_nettype wire

/* verilog/ex_stage_top.sv */
// execute stage top level with the ALUs, hi/lo unit and write-back register
`timescale 1ns/1ps
`default_nettype none

module ex_stage_top import ex_pkg::*; #(
    parameter int REG_ADDR_W = 5
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  ex_req_t               i_req,
    input  logic [REG_ADDR_W-1:0] i_waddr,
    output ex_wb_t                o_wb,
    output logic [REG_ADDR_W-1:0] o_waddr,
    output logic                  o_stall,
    output hilo_t                 o_hilo
);

    logic [XLEN-1:0]   logic_out;
    logic [XLEN-1:0]   shift_out;
    logic [XLEN-1:0]   arith_out;
    logic              arith_ov;
    logic [2*XLEN-1:0] product;
    mac_state_e        mac_state;

    alu_logic_shift u_logic_shift (
        .i_req       (i_req),
        .o_logic_out (logic_out),
        .o_shift_out (shift_out)
    );

    alu_arith u_arith (
        .i_req       (i_req),
        .o_arith_out (arith_out),
        .o_ov        (arith_ov)
    );

    alu_mul u_mul (
        .i_req     (i_req),
        .o_product (product)
    );

    hilo_unit u_hilo (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_req       (i_req),
        .i_product   (product),
        .o_hilo      (o_hilo),
        .o_stall     (o_stall),
        .o_mac_state (mac_state)
    );

    ex_result_reg #(
        .REG_ADDR_W (REG_ADDR_W)
    ) u_result (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_req       (i_req),
        .i_waddr     (i_waddr),
        .i_logic_out (logic_out),
        .i_shift_out (shift_out),
        .i_arith_out (arith_out),
        .i_ov        (arith_ov),
        .i_product   (product),
        .i_hilo      (o_hilo),
        .i_stall     (o_stall),
        .o_wb        (o_wb),
        .o_waddr     (o_waddr)
    );

    // the accumulate cycle is accepted and written back
    a_acc_wb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (mac_state == MAC_ACC) |=> o_wb.vld);

endmodule

`default_nettype wire

/* verilog/hilo_unit.sv */
// hilo_unit: hi/lo registers, multiply-accumulate sequencer and issue stall
`timescale 1ns/1ps
`default_nettype none

module hilo_unit import ex_pkg::*; (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  ex_req_t           i_req,
    input  logic [2*XLEN-1:0] i_product,
    output hilo_t             o_hilo,
    output logic              o_stall,
    output mac_state_e        o_mac_state
);

    logic              is_mac;
    logic              is_msub;
    logic              accept;
    logic [2*XLEN-1:0] mac_tmp;   // product, already negated for msub

    assign is_mac  = i_req.alu_op inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
    assign is_msub = i_req.alu_op inside {OP_MSUB, OP_MSUBU};

    // first cycle of a madd/msub holds the issuing stage
    assign o_stall = i_req.vld && is_mac && (o_mac_state == MAC_IDLE);
    assign accept  = i_req.vld && !o_stall;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_mac_state <= MAC_IDLE;
            mac_tmp     <= '0;
        end else begin
            if (o_mac_state == MAC_IDLE) begin
                if (o_stall) begin
                    mac_tmp     <= is_msub ? (~i_product + 1'b1) : i_product;
                    o_mac_state <= MAC_ACC;
                end
            end else if (accept) begin
                o_mac_state <= MAC_IDLE;  // accumulate done this edge
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_hilo <= '0;
        end else if (accept) begin
            if (o_mac_state == MAC_ACC) begin
                o_hilo <= hilo_t'(o_hilo + mac_tmp);
            end else begin
                case (i_req.alu_op)
                OP_MULT, OP_MULTU: begin
                    o_hilo <= hilo_t'(i_product);
                end
                OP_MTHI: o_hilo.hi <= i_req.op0;  // lo kept
                OP_MTLO: o_hilo.lo <= i_req.op0;
                default: begin
                end
                endcase
            end
        end
    end

    // issuing stage must keep the madd/msub in place through the stall
    a_mac_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_mac_state == MAC_ACC) |-> (i_req.vld && is_mac));

endmodule

`default_nettype wire
